// File: src/mcu_cmd_pkg.sv
package mcu_cmd_pkg;

  // one command byte, read either as nibbles or as a whole opcode
  typedef union packed {
    struct packed {
      logic [3:0] grp;
      logic [3:0] sub;
    } f;
    logic [7:0] op;
  } mcu_cmd_u;

  // nibble groups, upper half of the command byte
  localparam logic [3:0] GRP_SET_ADDR  = 4'h0;
  localparam logic [3:0] GRP_ROM_MASK  = 4'h1;
  localparam logic [3:0] GRP_SAVE_MASK = 4'h2;
  localparam logic [3:0] GRP_MEM_RD    = 4'h8;
  localparam logic [3:0] GRP_MEM_WR    = 4'h9;

  // Ex/Fx commands decode the full byte
  localparam logic [7:0] OP_CX4_RESET = 8'hEB;
  localparam logic [7:0] OP_CX4_RUN   = 8'hEC;
  localparam logic [7:0] OP_FEATURES  = 8'hED;
  localparam logic [7:0] OP_REGION    = 8'hEE;
  localparam logic [7:0] OP_IDENT     = 8'hF0;
  localparam logic [7:0] OP_SYSCLK    = 8'hFE;
  localparam logic [7:0] OP_ECHO      = 8'hFF;

  // target in sub[1:0], sub[3] requests auto-increment
  localparam logic [1:0] TGT_SRAM = 2'd0;
  localparam logic [1:0] TGT_DAC  = 2'd1;
  localparam logic [1:0] TGT_MSU  = 2'd2;

  // config register selectors
  localparam logic [2:0] CFG_ROM    = 3'd0;
  localparam logic [2:0] CFG_SAVE   = 3'd1;
  localparam logic [2:0] CFG_FEAT   = 3'd2;
  localparam logic [2:0] CFG_REGION = 3'd3;
  localparam logic [2:0] CFG_CX4    = 3'd4;

  // response sources
  localparam logic [2:0] RB_ZERO  = 3'd0;
  localparam logic [2:0] RB_IDENT = 3'd1;
  localparam logic [2:0] RB_MEM   = 3'd2;
  localparam logic [2:0] RB_ECHO  = 3'd3;
  localparam logic [2:0] RB_FREQ  = 3'd4;

  localparam int SRAM_AW = 24;
  localparam int DAC_AW  = 11;
  localparam int MSU_AW  = 14;

endpackage

// File: src/spi_byte_rx.sv
`timescale 1ns/1ps

module spi_byte_rx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       spi_sclk,
  input  logic       spi_cs_n,
  input  logic       spi_mosi,
  output logic       spi_miso,
  input  logic [7:0] rb_byte,
  output logic       byte_valid,
  output logic       cs_start,
  output logic [7:0] byte_data,
  output logic [3:0] byte_idx
);

  // bit 1 is the synchronized level, bit 2 the previous one
  logic [2:0] sclk_sync;
  logic [2:0] cs_sync;
  logic [1:0] mosi_sync;
  logic       sclk_rise;
  logic       sclk_fall;
  logic       cs_active;
  logic [2:0] bit_cnt;
  logic [7:0] rx_shift;
  logic [7:0] tx_shift;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sclk_sync <= '0;
      cs_sync   <= '1;
      mosi_sync <= '0;
    end else begin
      sclk_sync <= {sclk_sync[1:0], spi_sclk};
      cs_sync   <= {cs_sync[1:0], spi_cs_n};
      mosi_sync <= {mosi_sync[0], spi_mosi};
    end
  end

  assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
  assign sclk_fall = ~sclk_sync[1] & sclk_sync[2];
  assign cs_active = ~cs_sync[1];

  //////////////////////////////////////////////////
  // receive side
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt    <= '0;
      byte_idx   <= '0;
      byte_valid <= 1'b0;
      cs_start   <= 1'b0;
    end else begin
      byte_valid <= 1'b0;
      cs_start   <= cs_sync[2] & ~cs_sync[1];
      if (!cs_active) begin
        bit_cnt  <= '0;
        byte_idx <= '0;
      end else if (sclk_rise) begin
        bit_cnt <= bit_cnt + 3'd1;
        if (bit_cnt == 3'd7) begin
          byte_valid <= 1'b1;
          // saturates, long transactions stay at 15
          if (byte_idx != 4'hF) begin
            byte_idx <= byte_idx + 4'd1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cs_active && sclk_rise) begin
      rx_shift <= {rx_shift[6:0], mosi_sync[1]};
    end
  end

  assign byte_data = rx_shift;

  //////////////////////////////////////////////////
  // transmit side
  //////////////////////////////////////////////////

  // between bytes the shifter follows rb_byte until the first rising edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_shift <= '0;
    end else if (!cs_active) begin
      tx_shift <= '0;
    end else if (bit_cnt == 3'd0) begin
      tx_shift <= (byte_idx == 4'd0) ? 8'h00 : rb_byte;
    end else if (sclk_fall) begin
      tx_shift <= {tx_shift[6:0], 1'b0};
    end
  end

  assign spi_miso = tx_shift[7];

endmodule

// File: src/mcu_cmd_ctrl.sv
`timescale 1ns/1ps

module mcu_cmd_ctrl import mcu_cmd_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       byte_valid,
  input  logic       cs_start,
  input  logic [7:0] byte_data,
  input  logic [3:0] byte_idx,
  input  logic       mem_ack,
  output logic       mem_req,
  output logic       mem_we,
  output logic       mem_done,
  output logic [1:0] mem_target,
  output logic [7:0] mem_wdata,
  output logic       addr_wr,
  output logic       addr_inc,
  output logic [1:0] addr_tgt,
  output logic [1:0] inc_tgt,
  output logic [1:0] addr_byte,
  output logic       cfg_wr,
  output logic [2:0] cfg_sel,
  output logic [1:0] cfg_byte,
  output logic [7:0] wdata,
  output logic       rb_load,
  output logic       rb_snap,
  output logic [2:0] rb_sel,
  output logic [3:0] rb_byte_idx
);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_REQ  = 2'd1;
  localparam logic [1:0] ST_WAIT = 2'd2;

  mcu_cmd_u   cmd;
  mcu_cmd_u   cur;
  logic [1:0] state;
  logic       mem_inc;
  logic       param;
  logic       in_field;
  logic [1:0] field_pos;
  logic       mem_go;
  logic       addr_wr_d;
  logic       cfg_wr_d;
  logic [2:0] cfg_sel_d;
  logic [7:0] wdata_d;
  logic       rb_load_d;
  logic [2:0] rb_sel_d;

  // byte 1 decodes straight from the wire
  always_comb begin
    cur.op = (byte_idx == 4'd1) ? byte_data : cmd.op;
  end

  assign param     = byte_idx >= 4'd2;
  assign in_field  = param && byte_idx <= 4'd4;
  assign field_pos = byte_idx[1:0] - 2'd2;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cmd.op <= 8'h00;
    end else if (byte_valid && byte_idx == 4'd1) begin
      cmd.op <= byte_data;
    end
  end

  //////////////////////////////////////////////////
  // byte decode
  //////////////////////////////////////////////////

  always_comb begin
    addr_wr_d = 1'b0;
    cfg_wr_d  = 1'b0;
    cfg_sel_d = CFG_ROM;
    wdata_d   = byte_data;
    rb_load_d = 1'b0;
    rb_sel_d  = RB_ZERO;
    if (byte_valid) begin
      // read data arrives later, at mem_done
      rb_load_d = cur.f.grp != GRP_MEM_RD;
      case (cur.f.grp)
        GRP_SET_ADDR: addr_wr_d = in_field;
        GRP_ROM_MASK: cfg_wr_d = in_field;
        GRP_SAVE_MASK: begin
          cfg_wr_d  = in_field;
          cfg_sel_d = CFG_SAVE;
        end
        default: ;
      endcase
      case (cur.op)
        OP_CX4_RESET, OP_CX4_RUN: begin
          cfg_wr_d  = 1'b1;
          cfg_sel_d = CFG_CX4;
          wdata_d   = {7'd0, cur.op == OP_CX4_RESET};
        end
        OP_FEATURES: begin
          cfg_wr_d  = param;
          cfg_sel_d = CFG_FEAT;
        end
        OP_REGION: begin
          cfg_wr_d  = param;
          cfg_sel_d = CFG_REGION;
        end
        OP_IDENT:  rb_sel_d = RB_IDENT;
        OP_SYSCLK: rb_sel_d = RB_FREQ;
        OP_ECHO:   rb_sel_d = RB_ECHO;
        default: ;
      endcase
    end
    if (mem_done && !mem_we) begin
      rb_load_d = 1'b1;
      rb_sel_d  = RB_MEM;
    end else if (cs_start) begin
      // no stale response into a new transaction
      rb_load_d = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_wr  <= 1'b0;
      cfg_wr   <= 1'b0;
      rb_load  <= 1'b0;
      rb_snap  <= 1'b0;
      rb_sel   <= RB_ZERO;
      addr_inc <= 1'b0;
    end else begin
      addr_wr  <= addr_wr_d;
      cfg_wr   <= cfg_wr_d;
      rb_load  <= rb_load_d;
      rb_sel   <= rb_sel_d;
      rb_snap  <= byte_valid && byte_idx == 4'd1 && cur.op == OP_SYSCLK;
      addr_inc <= mem_done && mem_inc;
    end
  end

  always_ff @(posedge clk) begin
    inc_tgt <= mem_target;
    if (byte_valid) begin
      wdata       <= wdata_d;
      addr_tgt    <= cur.f.sub[1:0];
      addr_byte   <= field_pos;
      cfg_sel     <= cfg_sel_d;
      cfg_byte    <= field_pos;
      rb_byte_idx <= byte_idx;
    end
    if (mem_go) begin
      mem_wdata <= byte_data;
    end
  end

  //////////////////////////////////////////////////
  // memory handshake
  //////////////////////////////////////////////////

  // a byte arriving while a request is pending loses its access
  assign mem_go = byte_valid
                  && (cur.f.grp == GRP_MEM_RD || (cur.f.grp == GRP_MEM_WR && param))
                  && (state == ST_IDLE || (state == ST_WAIT && !mem_ack));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= ST_IDLE;
      mem_req    <= 1'b0;
      mem_done   <= 1'b0;
      mem_we     <= 1'b0;
      mem_target <= TGT_SRAM;
      mem_inc    <= 1'b0;
    end else begin
      mem_done <= 1'b0;
      if (state == ST_REQ) begin
        if (mem_ack) begin
          mem_req  <= 1'b0;
          mem_done <= 1'b1;
          state    <= ST_WAIT;
        end
      end else if (mem_go) begin
        mem_req    <= 1'b1;
        mem_we     <= cur.f.grp == GRP_MEM_WR;
        mem_target <= cur.f.sub[1:0];
        mem_inc    <= cur.f.sub[3];
        state      <= ST_REQ;
      end else if (state == ST_WAIT && !mem_ack) begin
        state <= ST_IDLE;
      end
    end
  end

endmodule

// File: src/mcu_addr_gen.sv
`timescale 1ns/1ps

module mcu_addr_gen import mcu_cmd_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               addr_wr,
  input  logic               addr_inc,
  input  logic [1:0]         addr_tgt,
  input  logic [1:0]         inc_tgt,
  input  logic [1:0]         addr_byte,
  input  logic [7:0]         wdata,
  output logic [SRAM_AW-1:0] sram_addr,
  output logic [DAC_AW-1:0]  dac_addr,
  output logic [MSU_AW-1:0]  msu_addr
);

  // top byte first, it clears the bytes below it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sram_addr <= '0;
    end else if (addr_wr && addr_tgt == TGT_SRAM) begin
      case (addr_byte)
        2'd0:    sram_addr <= {wdata, 16'h0000};
        2'd1:    sram_addr[15:8] <= wdata;
        default: sram_addr[7:0] <= wdata;
      endcase
    end else if (addr_inc && inc_tgt == TGT_SRAM) begin
      sram_addr <= sram_addr + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dac_addr <= '0;
    end else if (addr_wr && addr_tgt == TGT_DAC) begin
      if (addr_byte == 2'd0) begin
        dac_addr <= {wdata[DAC_AW-9:0], 8'h00};
      end else if (addr_byte == 2'd1) begin
        dac_addr[7:0] <= wdata;
      end
    end else if (addr_inc && inc_tgt == TGT_DAC) begin
      dac_addr <= dac_addr + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      msu_addr <= '0;
    end else if (addr_wr && addr_tgt == TGT_MSU) begin
      if (addr_byte == 2'd0) begin
        msu_addr <= {wdata[MSU_AW-9:0], 8'h00};
      end else if (addr_byte == 2'd1) begin
        msu_addr[7:0] <= wdata;
      end
    end else if (addr_inc && inc_tgt == TGT_MSU) begin
      msu_addr <= msu_addr + 1'b1;
    end
  end

endmodule

// File: src/mcu_cfg_regs.sv
`timescale 1ns/1ps

module mcu_cfg_regs import mcu_cmd_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        cfg_wr,
  input  logic [2:0]  cfg_sel,
  input  logic [1:0]  cfg_byte,
  input  logic [7:0]  wdata,
  output logic [23:0] rom_mask,
  output logic [23:0] saveram_mask,
  output logic [7:0]  featurebits,
  output logic        region,
  output logic        cx4_reset
);

  // byte 0 is the high byte
  function automatic logic [23:0] put_byte(
    input logic [23:0] mask,
    input logic [1:0]  pos,
    input logic [7:0]  data
  );
    logic [23:0] res;
    res = mask;
    case (pos)
      2'd0:    res[23:16] = data;
      2'd1:    res[15:8] = data;
      default: res[7:0] = data;
    endcase
    return res;
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rom_mask     <= '1;
      saveram_mask <= '1;
      featurebits  <= '0;
      region       <= 1'b0;
      // coprocessor held until released
      cx4_reset    <= 1'b1;
    end else if (cfg_wr) begin
      case (cfg_sel)
        CFG_ROM:    rom_mask <= put_byte(rom_mask, cfg_byte, wdata);
        CFG_SAVE:   saveram_mask <= put_byte(saveram_mask, cfg_byte, wdata);
        CFG_FEAT:   featurebits <= wdata;
        CFG_REGION: region <= wdata[0];
        CFG_CX4:    cx4_reset <= wdata[0];
        default: ;
      endcase
    end
  end

endmodule

// File: src/sysclk_meter.sv
`timescale 1ns/1ps

module sysclk_meter #(
  parameter int GATE_CYCLES = 1000
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        snes_sysclk,
  output logic [31:0] freq_count
);

  logic [2:0]  sys_sync;
  logic        sys_rise;
  logic [31:0] gate_cnt;
  logic [31:0] edge_cnt;
  logic        gate_end;

  assign sys_rise = sys_sync[1] & ~sys_sync[2];
  assign gate_end = gate_cnt == 32'(GATE_CYCLES - 1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sys_sync   <= '0;
      gate_cnt   <= '0;
      edge_cnt   <= '0;
      freq_count <= '0;
    end else begin
      sys_sync <= {sys_sync[1:0], snes_sysclk};
      if (gate_end) begin
        // publish and open the next window
        gate_cnt   <= '0;
        freq_count <= edge_cnt + 32'(sys_rise);
        edge_cnt   <= '0;
      end else begin
        gate_cnt <= gate_cnt + 32'd1;
        edge_cnt <= edge_cnt + 32'(sys_rise);
      end
    end
  end

endmodule

// File: src/mcu_readback.sv
`timescale 1ns/1ps

module mcu_readback import mcu_cmd_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        rb_load,
  input  logic        rb_snap,
  input  logic        mem_done,
  input  logic [2:0]  rb_sel,
  input  logic [3:0]  rb_byte_idx,
  input  logic [7:0]  mem_rdata,
  input  logic [7:0]  wdata,
  input  logic [31:0] freq_count,
  output logic [7:0]  rb_byte
);

  logic [31:0] snap;
  logic [31:0] freq_src;
  logic [7:0]  mem_q;

  always_ff @(posedge clk) begin
    if (rb_snap) begin
      snap <= freq_count;
    end
    if (mem_done) begin
      mem_q <= mem_rdata;
    end
  end

  // first byte goes out in the same cycle as the snapshot
  assign freq_src = rb_snap ? freq_count : snap;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rb_byte <= '0;
    end else if (rb_load) begin
      case (rb_sel)
        RB_IDENT: rb_byte <= 8'hA5;
        RB_MEM:   rb_byte <= mem_q;
        RB_ECHO:  rb_byte <= wdata;
        RB_FREQ: begin
          case (rb_byte_idx)
            4'd1:    rb_byte <= freq_src[31:24];
            4'd2:    rb_byte <= freq_src[23:16];
            4'd3:    rb_byte <= freq_src[15:8];
            4'd4:    rb_byte <= freq_src[7:0];
            default: rb_byte <= 8'h00;
          endcase
        end
        default: rb_byte <= 8'h00;
      endcase
    end
  end

endmodule

// File: src/mcu_cmd_top.sv
`timescale 1ns/1ps

module mcu_cmd_top import mcu_cmd_pkg::*; #(
  parameter int GATE_CYCLES = 1000
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               spi_sclk,
  input  logic               spi_cs_n,
  input  logic               spi_mosi,
  output logic               spi_miso,
  input  logic               snes_sysclk,
  output logic               mem_req,
  output logic               mem_we,
  output logic [1:0]         mem_target,
  output logic [7:0]         mem_wdata,
  input  logic [7:0]         mem_rdata,
  input  logic               mem_ack,
  output logic [SRAM_AW-1:0] sram_addr,
  output logic [DAC_AW-1:0]  dac_addr,
  output logic [MSU_AW-1:0]  msu_addr,
  output logic [23:0]        rom_mask,
  output logic [23:0]        saveram_mask,
  output logic [7:0]         featurebits,
  output logic               region,
  output logic               cx4_reset
);

  logic        byte_valid;
  logic        cs_start;
  logic [7:0]  byte_data;
  logic [3:0]  byte_idx;
  logic [7:0]  rb_byte;
  logic        mem_done;
  logic        addr_wr;
  logic        addr_inc;
  logic [1:0]  addr_tgt;
  logic [1:0]  inc_tgt;
  logic [1:0]  addr_byte;
  logic        cfg_wr;
  logic [2:0]  cfg_sel;
  logic [1:0]  cfg_byte;
  logic [7:0]  wdata;
  logic        rb_load;
  logic        rb_snap;
  logic [2:0]  rb_sel;
  logic [3:0]  rb_byte_idx;
  logic [31:0] freq_count;

  spi_byte_rx u_spi (
    .clk(clk), .rst_n(rst_n),
    .spi_sclk(spi_sclk), .spi_cs_n(spi_cs_n), .spi_mosi(spi_mosi), .spi_miso(spi_miso),
    .rb_byte(rb_byte), .byte_valid(byte_valid), .cs_start(cs_start),
    .byte_data(byte_data), .byte_idx(byte_idx)
  );

  mcu_cmd_ctrl u_ctrl (
    .clk(clk), .rst_n(rst_n),
    .byte_valid(byte_valid), .cs_start(cs_start), .byte_data(byte_data), .byte_idx(byte_idx),
    .mem_ack(mem_ack), .mem_req(mem_req), .mem_we(mem_we), .mem_done(mem_done),
    .mem_target(mem_target), .mem_wdata(mem_wdata),
    .addr_wr(addr_wr), .addr_inc(addr_inc), .addr_tgt(addr_tgt), .inc_tgt(inc_tgt),
    .addr_byte(addr_byte), .cfg_wr(cfg_wr), .cfg_sel(cfg_sel), .cfg_byte(cfg_byte),
    .wdata(wdata), .rb_load(rb_load), .rb_snap(rb_snap), .rb_sel(rb_sel),
    .rb_byte_idx(rb_byte_idx)
  );

  mcu_addr_gen u_addr (
    .clk(clk), .rst_n(rst_n),
    .addr_wr(addr_wr), .addr_inc(addr_inc), .addr_tgt(addr_tgt), .inc_tgt(inc_tgt),
    .addr_byte(addr_byte), .wdata(wdata),
    .sram_addr(sram_addr), .dac_addr(dac_addr), .msu_addr(msu_addr)
  );

  mcu_cfg_regs u_cfg (
    .clk(clk), .rst_n(rst_n),
    .cfg_wr(cfg_wr), .cfg_sel(cfg_sel), .cfg_byte(cfg_byte), .wdata(wdata),
    .rom_mask(rom_mask), .saveram_mask(saveram_mask), .featurebits(featurebits),
    .region(region), .cx4_reset(cx4_reset)
  );

  sysclk_meter #(
    .GATE_CYCLES(GATE_CYCLES)
  ) u_meter (
    .clk(clk), .rst_n(rst_n), .snes_sysclk(snes_sysclk), .freq_count(freq_count)
  );

  mcu_readback u_rb (
    .clk(clk), .rst_n(rst_n),
    .rb_load(rb_load), .rb_snap(rb_snap), .mem_done(mem_done), .rb_sel(rb_sel),
    .rb_byte_idx(rb_byte_idx), .mem_rdata(mem_rdata), .wdata(wdata),
    .freq_count(freq_count), .rb_byte(rb_byte)
  );

endmodule

// File: dv/mcu_cmd_properties.sv
`timescale 1ns/1ps

module mcu_cmd_properties (
  input logic clk,
  input logic rst_n,
  input logic mem_req,
  input logic mem_ack,
  input logic byte_valid
);

  // request stays up until the memory answers
  req_held_until_ack: assert property (
    @(posedge clk) disable iff (!rst_n)
    mem_req && !mem_ack |=> mem_req
  ) else $error("mem_req dropped before mem_ack");

  // a new request waits for ack low
  no_req_during_ack: assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(mem_req) |-> !mem_ack
  ) else $error("mem_req raised while mem_ack still high");

  // spi bytes are slow enough that the handshake is always finished
  no_byte_while_pending: assert property (
    @(posedge clk) disable iff (!rst_n)
    byte_valid |-> !(mem_req || mem_ack)
  ) else $error("byte arrived during a memory handshake");

endmodule

// File: dv/mcu_cmd_tb.sv
`timescale 1ns/1ps

module mcu_cmd_tb import mcu_cmd_pkg::*; ();

  localparam int CLK_PERIOD  = 20;
  localparam int SYS_HALF    = 23;
  localparam int GATE_CYCLES = 460;
  localparam int SPI_HALF    = 8;
  localparam int BYTE_GAP    = 16;
  localparam int WR_LEN      = 8;
  localparam int RD_LEN      = 6;
  // about 70 bytes of spi traffic, twice over
  localparam int TIMEOUT_CYCLES = 2 * 70 * (16 * SPI_HALF + BYTE_GAP);

  logic               clk;
  logic               rst_n;
  logic               spi_sclk;
  logic               spi_cs_n;
  logic               spi_mosi;
  logic               spi_miso;
  logic               snes_sysclk;
  logic               mem_req;
  logic               mem_we;
  logic [1:0]         mem_target;
  logic [7:0]         mem_wdata;
  logic [7:0]         mem_rdata = 8'h00;
  logic               mem_ack = 1'b0;
  logic [SRAM_AW-1:0] sram_addr;
  logic [DAC_AW-1:0]  dac_addr;
  logic [MSU_AW-1:0]  msu_addr;
  logic [23:0]        rom_mask;
  logic [23:0]        saveram_mask;
  logic [7:0]         featurebits;
  logic               region;
  logic               cx4_reset;

  logic [7:0]         mosi_q[$];
  logic [7:0]         miso_q[$];
  logic [SRAM_AW-1:0] wr_addr_q[$];
  logic [7:0]         wr_data_q[$];
  logic [7:0]         mem_model [0:3][0:255];
  logic [31:0]        data_seed = 32'd36458;
  logic [31:0]        delay_seed = 32'd36458;
  logic [1:0]         ack_wait;
  logic               busy;
  string              cur_test;
  int                 checks;
  int                 errors;
  int                 test_errs;
  int                 cycle_cnt;

  mcu_cmd_top #(
    .GATE_CYCLES(GATE_CYCLES)
  ) UUT (.*);

  bind mcu_cmd_ctrl mcu_cmd_properties u_props (
    .clk(clk), .rst_n(rst_n), .mem_req(mem_req), .mem_ack(mem_ack), .byte_valid(byte_valid)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    snes_sysclk = 1'b0;
    forever #(SYS_HALF) snes_sysclk = ~snes_sysclk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, tests did not complete", cycle_cnt);
      $display("sim failed");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // distinct value for every address of a page
  function automatic logic [7:0] fill_byte(input int page, input int addr);
    return 8'((addr * 37 + page * 91 + 17) % 256);
  endfunction

  function automatic logic [7:0] make_cmd(input logic [3:0] grp, input logic [3:0] sub);
    mcu_cmd_u c;
    c.f.grp = grp;
    c.f.sub = sub;
    return c.op;
  endfunction

  function automatic logic [7:0] page_addr(input logic [1:0] tgt);
    case (tgt)
      TGT_DAC: return dac_addr[7:0];
      TGT_MSU: return msu_addr[7:0];
      default: return sram_addr[7:0];
    endcase
  endfunction

  //////////////////////////////////////////////////
  // memory responder
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!rst_n) begin
      mem_ack  <= 1'b0;
      busy     <= 1'b0;
      ack_wait <= '0;
      for (int p = 0; p < 4; p++) begin
        for (int a = 0; a < 256; a++) begin
          mem_model[p][a] <= fill_byte(p, a);
        end
      end
    end else if (mem_ack) begin
      // ack held until req drops
      if (!mem_req) begin
        mem_ack <= 1'b0;
      end
    end else if (mem_req && !busy) begin
      delay_seed = lcg_next(delay_seed);
      busy     <= 1'b1;
      ack_wait <= delay_seed[17:16];
    end else if (busy) begin
      if (ack_wait == 2'd0) begin
        busy    <= 1'b0;
        mem_ack <= 1'b1;
        if (mem_we) begin
          mem_model[mem_target][page_addr(mem_target)] <= mem_wdata;
          wr_addr_q.push_back(sram_addr);
          wr_data_q.push_back(mem_wdata);
        end else begin
          mem_rdata <= mem_model[mem_target][page_addr(mem_target)];
        end
      end else begin
        ack_wait <= ack_wait - 2'd1;
      end
    end
  end

  //////////////////////////////////////////////////
  // spi master and checks
  //////////////////////////////////////////////////

  // sends mosi_q in one transaction, collects miso_q
  task automatic spi_transfer();
    logic [7:0] rx;
    rx = 8'h00;
    miso_q.delete();
    spi_cs_n <= 1'b0;
    repeat (SPI_HALF) @(posedge clk);
    foreach (mosi_q[i]) begin
      for (int b = 7; b >= 0; b--) begin
        spi_mosi <= mosi_q[i][b];
        repeat (SPI_HALF) @(posedge clk);
        // miso settled long before the rising edge
        rx = {rx[6:0], spi_miso};
        spi_sclk <= 1'b1;
        repeat (SPI_HALF) @(posedge clk);
        spi_sclk <= 1'b0;
      end
      miso_q.push_back(rx);
      repeat (BYTE_GAP) @(posedge clk);
    end
    spi_cs_n <= 1'b1;
    repeat (BYTE_GAP) @(posedge clk);
  endtask

  task automatic load_sram_addr(input logic [SRAM_AW-1:0] addr);
    mosi_q = {make_cmd(GRP_SET_ADDR, {2'b00, TGT_SRAM}), addr[23:16], addr[15:8], addr[7:0]};
    spi_transfer();
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    if (test_errs == 0) begin
      $display("%s: ok", cur_test);
    end else begin
      $display("%s: %0d errors", cur_test, test_errs);
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      test_errs++;
      $display("Error %s %s: expected %b, actual %b", cur_test, what, exp, act);
    end
  endtask

  task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      test_errs++;
      $display("Error %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_addr(input string what, input logic [23:0] exp, input logic [23:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      test_errs++;
      $display("Error %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_count(input string what, input logic [31:0] exp, input logic [31:0] act);
    longint diff;
    checks++;
    diff = longint'(act) - longint'(exp);
    if ($isunknown(act) || diff > 1 || diff < -1) begin
      errors++;
      test_errs++;
      $display("Error %s %s: expected %0d (+-1), actual %0d", cur_test, what, exp, act);
    end
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////

  task automatic reset_and_config();
    begin_test("reset_and_config");
    check_bit("mem_req", 1'b0, mem_req);
    check_bit("spi_miso", 1'b0, spi_miso);
    check_bit("cx4_reset", 1'b1, cx4_reset);
    check_bit("region", 1'b0, region);
    check_byte("featurebits", 8'h00, featurebits);
    check_addr("rom_mask", 24'hFFFFFF, rom_mask);
    check_addr("saveram_mask", 24'hFFFFFF, saveram_mask);
    check_addr("sram_addr", 24'h0, sram_addr);
    check_addr("dac_addr", 24'h0, 24'(dac_addr));
    check_addr("msu_addr", 24'h0, 24'(msu_addr));
    mosi_q = {OP_FEATURES, 8'h5C};
    spi_transfer();
    check_byte("featurebits", 8'h5C, featurebits);
    mosi_q = {OP_REGION, 8'h01};
    spi_transfer();
    check_bit("region", 1'b1, region);
    mosi_q = {OP_CX4_RUN};
    spi_transfer();
    check_bit("cx4_reset after run", 1'b0, cx4_reset);
    mosi_q = {OP_CX4_RESET};
    spi_transfer();
    check_bit("cx4_reset after reset", 1'b1, cx4_reset);
    mosi_q = {make_cmd(GRP_ROM_MASK, 4'h0), 8'h3F, 8'h7E, 8'hC1};
    spi_transfer();
    check_addr("rom_mask", 24'h3F7EC1, rom_mask);
    mosi_q = {make_cmd(GRP_SAVE_MASK, 4'h0), 8'h01, 8'hFF, 8'h80};
    spi_transfer();
    check_addr("saveram_mask", 24'h01FF80, saveram_mask);
    end_test();
  endtask

  task automatic address_load();
    logic [15:0] pair;
    begin_test("address_load");
    load_sram_addr(24'hA1B2C3);
    check_addr("sram_addr", 24'hA1B2C3, sram_addr);
    // top byte alone clears the rest
    mosi_q = {make_cmd(GRP_SET_ADDR, {2'b00, TGT_SRAM}), 8'h4D};
    spi_transfer();
    check_addr("sram_addr top byte", 24'h4D0000, sram_addr);
    pair = 16'hFE9B;
    mosi_q = {make_cmd(GRP_SET_ADDR, {2'b00, TGT_DAC}), pair[15:8], pair[7:0]};
    spi_transfer();
    check_addr("dac_addr", 24'(pair[DAC_AW-1:0]), 24'(dac_addr));
    pair = 16'h9C37;
    mosi_q = {make_cmd(GRP_SET_ADDR, {2'b00, TGT_MSU}), pair[15:8], pair[7:0]};
    spi_transfer();
    check_addr("msu_addr", 24'(pair[MSU_AW-1:0]), 24'(msu_addr));
    end_test();
  endtask

  task automatic memory_write();
    logic [7:0]         data [WR_LEN];
    logic [SRAM_AW-1:0] start;
    begin_test("memory_write");
    // low byte near the top, the pointer carries
    start = 24'h1234F8;
    load_sram_addr(start);
    wr_addr_q.delete();
    wr_data_q.delete();
    mosi_q = {make_cmd(GRP_MEM_WR, {2'b10, TGT_SRAM})};
    for (int k = 0; k < WR_LEN; k++) begin
      data_seed = lcg_next(data_seed);
      data[k] = data_seed[23:16];
      mosi_q.push_back(data[k]);
    end
    spi_transfer();
    check_byte("write requests", 8'(WR_LEN), 8'(wr_addr_q.size()));
    for (int k = 0; k < WR_LEN && k < wr_addr_q.size(); k++) begin
      check_addr("write address", start + 24'(k), wr_addr_q[k]);
      check_byte("write data", data[k], wr_data_q[k]);
    end
    for (int k = 0; k < WR_LEN; k++) begin
      check_byte("memory contents", data[k], mem_model[TGT_SRAM][8'(start + 24'(k))]);
    end
    check_addr("final sram_addr", start + 24'(WR_LEN), sram_addr);
    end_test();
  endtask

  task automatic memory_read();
    logic [SRAM_AW-1:0] start;
    begin_test("memory_read");
    start = 24'h0000FC;
    load_sram_addr(start);
    mosi_q = {make_cmd(GRP_MEM_RD, {2'b10, TGT_SRAM})};
    for (int k = 0; k < RD_LEN; k++) begin
      mosi_q.push_back(8'h00);
    end
    spi_transfer();
    check_byte("command byte miso", 8'h00, miso_q[0]);
    // data of access k shows up in byte k+2
    for (int k = 0; k < RD_LEN; k++) begin
      check_byte("read data", mem_model[TGT_SRAM][8'(start + 24'(k))], miso_q[k + 1]);
    end
    check_addr("final sram_addr", start + 24'(RD_LEN + 1), sram_addr);
    end_test();
  endtask

  task automatic ident_and_echo();
    begin_test("ident_and_echo");
    mosi_q = {OP_IDENT, 8'h11, 8'h22, 8'h33, 8'h44};
    spi_transfer();
    check_byte("ident first byte", 8'h00, miso_q[0]);
    for (int k = 1; k < miso_q.size(); k++) begin
      check_byte("ident", 8'hA5, miso_q[k]);
    end
    mosi_q = {OP_ECHO};
    for (int k = 0; k < 4; k++) begin
      data_seed = lcg_next(data_seed);
      mosi_q.push_back(data_seed[23:16]);
    end
    spi_transfer();
    check_byte("echo first byte", 8'h00, miso_q[0]);
    for (int k = 1; k < miso_q.size(); k++) begin
      check_byte("echo", mosi_q[k - 1], miso_q[k]);
    end
    end_test();
  endtask

  task automatic sysclk_measure();
    logic [31:0] meas;
    begin_test("sysclk_measure");
    mosi_q = {OP_SYSCLK, 8'h00, 8'h00, 8'h00, 8'h00};
    spi_transfer();
    meas = {miso_q[1], miso_q[2], miso_q[3], miso_q[4]};
    check_count("sysclk count", 32'(GATE_CYCLES * CLK_PERIOD / (2 * SYS_HALF)), meas);
    end_test();
  endtask

  initial begin
    rst_n    = 1'b0;
    spi_sclk = 1'b0;
    spi_cs_n = 1'b1;
    spi_mosi = 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    reset_and_config();
    address_load();
    memory_write();
    memory_read();
    ident_and_echo();
    // runs last so that several gate windows have closed
    sysclk_measure();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: mcu_cmd_top.f
src/mcu_cmd_pkg.sv
src/spi_byte_rx.sv
src/mcu_cmd_ctrl.sv
src/mcu_addr_gen.sv
src/mcu_cfg_regs.sv
src/sysclk_meter.sv
src/mcu_readback.sv
src/mcu_cmd_top.sv
dv/mcu_cmd_properties.sv
dv/mcu_cmd_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module mcu_cmd_tb -f mcu_cmd_top.f

status=0
./obj_dir/Vmcu_cmd_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "sim failed" sim.log || ! grep -q "sim passed" sim.log; then
  echo "simulation FAILED"
  exit 1
fi
echo "simulation PASSED"
